// File: include/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Memory map
`define CPU_ADDR_W    16
`define CPU_RESET_PC  16'h0200    // First opcode fetch after reset

// Zero-page read-modify-write shifts
`define OPC_ASL_ZPG   8'h06
`define OPC_LSR_ZPG   8'h46
`define OPC_ROL_ZPG   8'h26
`define OPC_ROR_ZPG   8'h66

// Implied instructions
`define OPC_CLC       8'h18
`define OPC_SEC       8'h38
`define OPC_NOP       8'hEA

`endif

// File: verilog/cpu_pkg.sv
`include "cpu_cfg.svh"

package cpu_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [`CPU_ADDR_W-1:0] addr_t;

    // Shift unit operation
    typedef enum logic [1:0] {
        ALU_ASL = 2'd0,
        ALU_LSR = 2'd1,
        ALU_ROL = 2'd2,
        ALU_ROR = 2'd3
    } alu_op_t;

    // Source of the memory address
    typedef enum logic {
        ADDR_PC  = 1'b0,
        ADDR_ZPG = 1'b1
    } addr_sel_t;

    typedef struct packed {
        logic n;    // Negative
        logic z;    // Zero
        logic c;    // Carry
    } flags_t;

    typedef enum logic [2:0] {
        S_IDLE         = 3'd0,
        S_OPCODE_READ  = 3'd1,
        S_ZPG_ADR_READ = 3'd2,
        S_IDL_WRITE    = 3'd3,
        S_ALU_ZPG      = 3'd4,
        S_DBUF_OUTPUT  = 3'd5,
        S_IMPLIED      = 3'd6
    } decode_state_t;

endpackage

// File: verilog/cpu_ctrl_if.sv
`timescale 1ns/1ps

interface cpu_ctrl_if import cpu_pkg::*; ();

    // Address unit strobes
    logic      pc_enable;
    logic      zpg_load;
    addr_sel_t addr_sel;

    // Datapath strobes
    logic      idl_load;
    logic      dbuf_load;
    alu_op_t   alu_op;

    // Status register controls
    flags_t    flag_write;    // Per-flag write mask
    logic      carry_set;
    logic      carry_clear;

    logic      mem_we;

    modport decoder (
        output pc_enable, zpg_load, addr_sel,
        output idl_load, dbuf_load, alu_op,
        output flag_write, carry_set, carry_clear,
        output mem_we
    );

    modport addr (input pc_enable, zpg_load, addr_sel);

    modport datapath (input idl_load, dbuf_load, alu_op);

    modport status (input flag_write, carry_set, carry_clear);

endinterface

// File: verilog/bus_latch.sv
`timescale 1ns/1ps

// Holding register shared by byte and address payloads
module bus_latch #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     load,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk) begin
        if (reset)
            q <= '0;
        else if (load)
            q <= d;    // Otherwise hold
    end

endmodule

// File: verilog/address_unit.sv
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module address_unit
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  byte_t mem_rdata,
    cpu_ctrl_if.addr ctrl,
    output addr_t mem_addr
);

    addr_t pc_q;
    addr_t zpg_addr;

    always_ff @(posedge clk) begin
        if (reset)
            pc_q <= `CPU_RESET_PC;
        else if (ctrl.pc_enable)
            pc_q <= pc_q + 1'b1;
    end

    // Zero-page address with the high byte forced to zero
    bus_latch #(
        .payload_t(addr_t)
    ) zpg_latch (
        .clk   (clk),
        .reset (reset),
        .load  (ctrl.zpg_load),
        .d     ({{(`CPU_ADDR_W - 8){1'b0}}, mem_rdata}),
        .q     (zpg_addr)
    );

    always_comb begin
        mem_addr = (ctrl.addr_sel == ADDR_ZPG) ? zpg_addr : pc_q;
    end

    // The zero-page byte comes from the program and never from zero page
    assert property (@(posedge clk) disable iff (reset)
        !(ctrl.zpg_load && (ctrl.addr_sel == ADDR_ZPG)));

endmodule

// File: verilog/instruction_decode.sv
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module instruction_decode
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  rdy,
    input  byte_t instruction,
    cpu_ctrl_if.decoder ctrl
);

    decode_state_t state_q;
    decode_state_t state_d;
    byte_t         opcode_q;
    logic          is_zpg_shift;

    // Group two (cc = 10) in zero-page mode (bbb = 001) with aaa below 4
    assign is_zpg_shift = (instruction[1:0] == 2'b10) && (instruction[4:2] == 3'b001)
                          && !instruction[7];

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q  <= S_IDLE;
            opcode_q <= `OPC_NOP;
        end else if (rdy) begin
            state_q <= state_d;
            if (state_q == S_OPCODE_READ)
                opcode_q <= instruction;
        end
    end

    always_comb begin
        state_d          = state_q;
        ctrl.pc_enable   = 1'b0;
        ctrl.zpg_load    = 1'b0;
        ctrl.addr_sel    = ADDR_PC;
        ctrl.idl_load    = 1'b0;
        ctrl.dbuf_load   = 1'b0;
        ctrl.flag_write  = '0;
        ctrl.carry_set   = 1'b0;
        ctrl.carry_clear = 1'b0;
        ctrl.mem_we      = 1'b0;

        // Shift selection follows the latched opcode
        case (opcode_q)
            `OPC_LSR_ZPG: ctrl.alu_op = ALU_LSR;
            `OPC_ROL_ZPG: ctrl.alu_op = ALU_ROL;
            `OPC_ROR_ZPG: ctrl.alu_op = ALU_ROR;
            default:      ctrl.alu_op = ALU_ASL;
        endcase

        case (state_q)
            S_IDLE: begin
                state_d = S_OPCODE_READ;
            end
            S_OPCODE_READ: begin
                ctrl.pc_enable = 1'b1;
                // Anything that is not a zero-page shift runs as implied
                state_d = is_zpg_shift ? S_ZPG_ADR_READ : S_IMPLIED;
            end
            S_ZPG_ADR_READ: begin
                ctrl.pc_enable = 1'b1;
                ctrl.zpg_load  = 1'b1;    // Operand byte is the zero-page address
                state_d        = S_IDL_WRITE;
            end
            S_IDL_WRITE: begin
                ctrl.addr_sel = ADDR_ZPG;
                ctrl.idl_load = 1'b1;
                state_d       = S_ALU_ZPG;
            end
            S_ALU_ZPG: begin
                ctrl.addr_sel   = ADDR_ZPG;
                ctrl.dbuf_load  = 1'b1;
                ctrl.flag_write = '{n: 1'b1, z: 1'b1, c: 1'b1};
                state_d         = S_DBUF_OUTPUT;
            end
            S_DBUF_OUTPUT: begin
                ctrl.addr_sel = ADDR_ZPG;
                ctrl.mem_we   = 1'b1;    // Write back the result
                state_d       = S_OPCODE_READ;
            end
            S_IMPLIED: begin
                ctrl.carry_set   = (opcode_q == `OPC_SEC);
                ctrl.carry_clear = (opcode_q == `OPC_CLC);
                state_d          = S_OPCODE_READ;
            end
            default: state_d = S_IDLE;
        endcase

        // A stalled cycle issues no strobes
        if (!rdy) begin
            ctrl.pc_enable   = 1'b0;
            ctrl.zpg_load    = 1'b0;
            ctrl.idl_load    = 1'b0;
            ctrl.dbuf_load   = 1'b0;
            ctrl.flag_write  = '0;
            ctrl.carry_set   = 1'b0;
            ctrl.carry_clear = 1'b0;
            ctrl.mem_we      = 1'b0;
        end
    end

    // Write-back lasts one cycle and the next fetch follows
    assert property (@(posedge clk) disable iff (reset)
        ctrl.mem_we |-> (state_q == S_DBUF_OUTPUT) ##1 (state_q == S_OPCODE_READ));

    assert property (@(posedge clk) disable iff (reset)
        !(ctrl.pc_enable && ctrl.mem_we));

    assert property (@(posedge clk) disable iff (reset)
        !rdy |-> !(ctrl.pc_enable || ctrl.zpg_load || ctrl.idl_load || ctrl.dbuf_load
                   || (|ctrl.flag_write) || ctrl.carry_set || ctrl.carry_clear
                   || ctrl.mem_we));

endmodule

// File: verilog/shift_alu.sv
`timescale 1ns/1ps

module shift_alu
    import cpu_pkg::*;
(
    input  byte_t   operand,
    input  logic    carry_in,
    input  alu_op_t op,
    output byte_t   result,
    output flags_t  flags
);

    logic carry_out;

    always_comb begin
        case (op)
            ALU_ASL: {carry_out, result} = {operand, 1'b0};
            ALU_ROL: {carry_out, result} = {operand, carry_in};    // Old carry into bit 0
            ALU_LSR: {result, carry_out} = {1'b0, operand};
            ALU_ROR: {result, carry_out} = {carry_in, operand};    // Old carry into bit 7
            default: {carry_out, result} = {operand, 1'b0};
        endcase

        flags.c = carry_out;
        flags.z = (result == 8'h00);
        flags.n = result[7];
    end

endmodule

// File: verilog/status_register.sv
`timescale 1ns/1ps

module status_register
    import cpu_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  flags_t alu_flags,
    cpu_ctrl_if.status ctrl,
    output flags_t flags
);

    always_ff @(posedge clk) begin
        if (reset) begin
            flags <= '0;
        end else begin
            if (ctrl.flag_write.n)
                flags.n <= alu_flags.n;
            if (ctrl.flag_write.z)
                flags.z <= alu_flags.z;

            // CLC and SEC take priority over the ALU carry
            if (ctrl.carry_set)
                flags.c <= 1'b1;
            else if (ctrl.carry_clear)
                flags.c <= 1'b0;
            else if (ctrl.flag_write.c)
                flags.c <= alu_flags.c;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        !(ctrl.carry_set && ctrl.carry_clear));

endmodule

// File: verilog/cpu_core.sv
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module cpu_core
    import cpu_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   rdy,
    input  logic [7:0]             mem_rdata,
    output logic [`CPU_ADDR_W-1:0] mem_addr,
    output logic [7:0]             mem_wdata,
    output logic                   mem_we,
    output logic                   flags_n,
    output logic                   flags_z,
    output logic                   flags_c
);

    cpu_ctrl_if ctrl_bus ();

    byte_t  idl_q;          // Operand read from zero page
    byte_t  alu_result;
    flags_t alu_flags;
    flags_t status_flags;

    instruction_decode decode (
        .clk         (clk),
        .reset       (reset),
        .rdy         (rdy),
        .instruction (mem_rdata),
        .ctrl        (ctrl_bus.decoder)
    );

    address_unit addr_unit (
        .clk       (clk),
        .reset     (reset),
        .mem_rdata (mem_rdata),
        .ctrl      (ctrl_bus.addr),
        .mem_addr  (mem_addr)
    );

    bus_latch #(.payload_t(byte_t)) input_data_latch (
        .clk   (clk),
        .reset (reset),
        .load  (ctrl_bus.idl_load),
        .d     (mem_rdata),
        .q     (idl_q)
    );

    shift_alu alu (
        .operand  (idl_q),
        .carry_in (status_flags.c),
        .op       (ctrl_bus.alu_op),
        .result   (alu_result),
        .flags    (alu_flags)
    );

    bus_latch #(.payload_t(byte_t)) data_buffer (
        .clk   (clk),
        .reset (reset),
        .load  (ctrl_bus.dbuf_load),
        .d     (alu_result),
        .q     (mem_wdata)
    );

    status_register status (
        .clk       (clk),
        .reset     (reset),
        .alu_flags (alu_flags),
        .ctrl      (ctrl_bus.status),
        .flags     (status_flags)
    );

    assign mem_we  = ctrl_bus.mem_we;
    assign flags_n = status_flags.n;
    assign flags_z = status_flags.z;
    assign flags_c = status_flags.c;

endmodule

// File: bench/cpu_core_tb.sv
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module cpu_core_tb;

    logic                   clk;
    logic                   reset;
    logic                   rdy;
    logic [7:0]             mem_rdata;
    logic [`CPU_ADDR_W-1:0] mem_addr;
    logic [7:0]             mem_wdata;
    logic                   mem_we;
    logic                   flags_n;
    logic                   flags_z;
    logic                   flags_c;

    logic [7:0] mem [0:65535];    // 64 KiB memory model

    // Stimulus table with one entry per instruction
    logic [7:0]  row_opcode [$];
    logic [7:0]  row_zpg [$];
    logic [7:0]  row_operand [$];

    // Expected write-backs from the reference model
    logic [15:0] exp_addr [$];
    logic [7:0]  exp_data [$];
    logic [2:0]  exp_flags [$];    // {n, z, c}

    logic [31:0] rng_state;
    logic [2:0]  final_flags;
    logic [15:0] nop_start;
    logic [15:0] last_addr;
    logic        was_stalled;
    logic        run_done;
    int          stall_left;
    int          post_reset_cycles;
    int          write_count;
    int          error_count;
    int          cycle_count;
    int          cycle_limit;

    cpu_core cpu_core_inst (
        .clk       (clk),
        .reset     (reset),
        .rdy       (rdy),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .flags_n   (flags_n),
        .flags_z   (flags_z),
        .flags_c   (flags_c)
    );

    always #2 clk = ~clk;

    assign mem_rdata = mem[mem_addr];    // Asynchronous read

    always @(posedge clk) begin
        if (mem_we)
            mem[mem_addr] <= mem_wdata;
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic is_shift(input logic [7:0] opcode);
        return (opcode == `OPC_ASL_ZPG) || (opcode == `OPC_LSR_ZPG)
            || (opcode == `OPC_ROL_ZPG) || (opcode == `OPC_ROR_ZPG);
    endfunction

    task automatic add_row(input logic [7:0] opcode, input logic [7:0] zpg);
        rng_state = next_random(rng_state);
        row_opcode.push_back(opcode);
        row_zpg.push_back(zpg);
        row_operand.push_back(rng_state[23:16]);
    endtask

    task automatic build_table();
        add_row(`OPC_SEC, 8'h00);
        add_row(`OPC_ROL_ZPG, 8'h10);    // Rotates in the set carry
        add_row(`OPC_ASL_ZPG, 8'h11);
        add_row(`OPC_LSR_ZPG, 8'h12);
        add_row(`OPC_CLC, 8'h00);
        add_row(`OPC_ROR_ZPG, 8'h13);    // Rotates in the cleared carry
        add_row(8'hC6, 8'h00);           // Unknown opcode runs as NOP
        add_row(`OPC_ROL_ZPG, 8'h14);
        add_row(`OPC_SEC, 8'h00);
        add_row(`OPC_ROR_ZPG, 8'h15);
        add_row(8'h02, 8'h00);           // Unknown opcode
        add_row(`OPC_ASL_ZPG, 8'h16);
        add_row(`OPC_NOP, 8'h00);
        add_row(`OPC_LSR_ZPG, 8'h17);
    endtask

    // Reference model walking the table with its own flags
    task automatic compute_expected();
        logic       c;
        logic       n;
        logic       z;
        logic [7:0] op;
        logic [7:0] res;
        c = 1'b0;
        n = 1'b0;
        z = 1'b0;
        for (int i = 0; i < row_opcode.size(); i++) begin
            op = row_operand[i];
            res = op;
            case (row_opcode[i])
                `OPC_CLC: c = 1'b0;
                `OPC_SEC: c = 1'b1;
                `OPC_ASL_ZPG: begin
                    res = {op[6:0], 1'b0};
                    c   = op[7];
                end
                `OPC_ROL_ZPG: begin
                    res = {op[6:0], c};
                    c   = op[7];
                end
                `OPC_LSR_ZPG: begin
                    res = {1'b0, op[7:1]};
                    c   = op[0];
                end
                `OPC_ROR_ZPG: begin
                    res = {c, op[7:1]};
                    c   = op[0];
                end
                default: ;    // NOP and unknown opcodes
            endcase
            if (is_shift(row_opcode[i])) begin
                n = res[7];
                z = (res == 8'h00);
                exp_addr.push_back({8'h00, row_zpg[i]});
                exp_data.push_back(res);
                exp_flags.push_back({n, z, c});
            end
        end
        final_flags = {n, z, c};
    endtask

    task automatic load_program();
        logic [15:0] pc;
        for (int a = 0; a < 65536; a++)
            mem[a] = a[15:8] ^ a[7:0] ^ 8'h5a;
        pc = `CPU_RESET_PC;
        for (int i = 0; i < row_opcode.size(); i++) begin
            mem[pc] = row_opcode[i];
            pc = pc + 16'd1;
            if (is_shift(row_opcode[i])) begin
                mem[pc] = row_zpg[i];
                pc = pc + 16'd1;
                mem[{8'h00, row_zpg[i]}] = row_operand[i];    // Operand preload
            end
        end
        nop_start = pc;
        for (int k = 0; k < 8; k++)
            mem[pc + k] = `OPC_NOP;    // Trailing NOP run
    endtask

    task automatic check_write();
        if (write_count >= exp_data.size()) begin
            $display("Unexpected write of %h to address %h at %0t", mem_wdata, mem_addr, $time);
            error_count++;
        end else begin
            if (mem_addr !== exp_addr[write_count]) begin
                $display("Error at %0t: mem_addr is %h, expected %h", $time, mem_addr,
                         exp_addr[write_count]);
                error_count++;
            end
            if (mem_wdata !== exp_data[write_count]) begin
                $display("Error at %0t: mem_wdata is %h, expected %h", $time, mem_wdata,
                         exp_data[write_count]);
                error_count++;
            end
            if (flags_n !== exp_flags[write_count][2]) begin
                $display("Error at %0t: flags_n is %b, expected %b", $time, flags_n,
                         exp_flags[write_count][2]);
                error_count++;
            end
            if (flags_z !== exp_flags[write_count][1]) begin
                $display("Error at %0t: flags_z is %b, expected %b", $time, flags_z,
                         exp_flags[write_count][1]);
                error_count++;
            end
            if (flags_c !== exp_flags[write_count][0]) begin
                $display("Error at %0t: flags_c is %b, expected %b", $time, flags_c,
                         exp_flags[write_count][0]);
                error_count++;
            end
        end
        write_count++;
    endtask

    // Random rdy stalls of one to four cycles
    always @(posedge clk) begin
        if (reset) begin
            rdy <= 1'b1;
        end else begin
            rng_state = next_random(rng_state);
            if (stall_left > 0) begin
                rdy <= 1'b0;
                stall_left = stall_left - 1;
            end else if (rng_state[31:29] == 3'd0) begin
                rdy <= 1'b0;
                stall_left = rng_state[1:0];
            end else begin
                rdy <= 1'b1;
            end
        end
    end

    // Output checks at the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            if (post_reset_cycles < 2 && mem_addr !== `CPU_RESET_PC) begin
                $display("Error at %0t: mem_addr is %h, expected %h", $time, mem_addr,
                         `CPU_RESET_PC);
                error_count++;
            end
            post_reset_cycles++;
            if (!rdy && mem_we !== 1'b0) begin
                $display("Error at %0t: mem_we is %b, expected 0", $time, mem_we);
                error_count++;
            end
            if (was_stalled && mem_addr !== last_addr) begin
                $display("Error at %0t: mem_addr is %h, expected %h", $time, mem_addr,
                         last_addr);
                error_count++;
            end
            last_addr = mem_addr;
            was_stalled = !rdy;
            if (mem_we === 1'b1)
                check_write();
            if (mem_addr == nop_start + 16'd1)
                run_done = 1'b1;    // Last instruction is complete
        end
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        rdy = 1'b1;
        rng_state = 32'hb60c_20aa;
        stall_left = 0;
        post_reset_cycles = 0;
        write_count = 0;
        error_count = 0;
        cycle_count = 0;
        run_done = 1'b0;
        was_stalled = 1'b0;
        last_addr = '0;
        build_table();
        compute_expected();
        load_program();
        cycle_limit = row_opcode.size() * 20 * 2 + 100;    // Doubled for rdy stalls

        repeat (3) @(posedge clk);
        reset <= 1'b0;

        while (!run_done && cycle_count < cycle_limit)
            @(posedge clk);

        if (!run_done) begin
            $display("Timeout: program end not reached within %0d cycles", cycle_limit);
            error_count++;
        end else begin
            if (write_count < exp_data.size()) begin
                $display("Too few writes: saw %0d, expected %0d", write_count, exp_data.size());
                error_count++;
            end
            if ({flags_n, flags_z, flags_c} !== final_flags) begin
                $display("Error at %0t: flags_nzc is %b, expected %b", $time,
                         {flags_n, flags_z, flags_c}, final_flags);
                error_count++;
            end
        end

        $display("Errors: %0d, writes: %0d of %0d, cycles: %0d", error_count, write_count,
                 exp_data.size(), cycle_count);
        if (error_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// File: flist.f
+incdir+include
verilog/cpu_pkg.sv
verilog/cpu_ctrl_if.sv
verilog/bus_latch.sv
verilog/address_unit.sv
verilog/instruction_decode.sv
verilog/shift_alu.sv
verilog/status_register.sv
verilog/cpu_core.sv
bench/cpu_core_tb.sv

// File: Bender.yml
package:
  name: cpu_core

sources:
  - include_dirs:
      - include
    files:
      - verilog/cpu_pkg.sv
      - verilog/cpu_ctrl_if.sv
      - verilog/bus_latch.sv
      - verilog/address_unit.sv
      - verilog/instruction_decode.sv
      - verilog/shift_alu.sv
      - verilog/status_register.sv
      - verilog/cpu_core.sv

  - target: test
    include_dirs:
      - include
    files:
      - bench/cpu_core_tb.sv
